//--- rename_core.f
hdl/ooo_pkg.sv
hdl/dispatch_buffer.sv
hdl/dispatch_stage.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/reservation_station.sv
hdl/rename_core.sv
verification/rename_core_tb.sv

//--- Bender.yml
package:
  name: rename_core

sources:
  - hdl/ooo_pkg.sv
  - hdl/dispatch_buffer.sv
  - hdl/dispatch_stage.sv
  - hdl/map_table.sv
  - hdl/free_list.sv
  - hdl/reservation_station.sv
  - hdl/rename_core.sv
  - target: simulation
    files:
      - verification/rename_core_tb.sv

//--- verification/rename_core_tb.sv
/* Testbench for the rename and dispatch front
   Plays fetch, completion and retirement, and checks issued packets by sequence id */
`timescale 1ns/100ps

module rename_core_tb
    import ooo_pkg::*;
();

    localparam int CLOCK_PERIOD = 40;
    localparam int PR_COUNT     = 64;
    localparam int RS_SIZE      = 8;
    localparam int CONSUMERS    = RS_SIZE + 4;
    // Cycle budget per test, plus slack
    localparam int WATCHDOG_CYCLES = 10 + 40 + 60 + 300 + 200 + 200;

    logic                clock = 1'b0;
    logic                reset;
    fetch_packet_t [2:0] fetch_group;
    logic [1:0]          fetch_take;
    cdb_t                cdb;
    retire_t [2:0]       retire;
    issue_packet_t [1:0] issue;

    // Reference rename state
    pr_t           ref_map [AR_COUNT];
    pr_t           ref_free [$];
    pr_t           displaced [$];
    pr_t           alloc_log [$];
    issue_packet_t expected [256];
    bit            outstanding [256];
    bit            seq_used [256];
    int            outstanding_count = 0;
    // Fetch side
    fetch_packet_t fetch_q [$];
    logic [1:0]    take_seen = '0;
    int            presented = 0;
    logic [31:0]   rand_state = 32'd1637;
    int            errors = 0;
    int            checks = 0;

    rename_core #(.pr_count(PR_COUNT), .rs_size(RS_SIZE)) dut0 (
        .clock(clock), .reset(reset), .fetch_group(fetch_group), .fetch_take(fetch_take),
        .cdb(cdb), .retire(retire), .issue(issue)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic int unsigned next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 16;
    endfunction

    // Ids stay unique for the whole run
    function automatic seq_t fresh_seq();
        seq_t s;
        s = seq_t'(next_random());
        while (seq_used[s]) begin
            s = seq_t'(next_random());
        end
        seq_used[s] = 1'b1;
        return s;
    endfunction

    function automatic fetch_packet_t make_instr(opcode_e op, ar_t d, ar_t s1, ar_t s2);
        fetch_packet_t p;
        p.valid  = 1'b1;
        p.opcode = op;
        p.dest   = d;
        p.src1   = s1;
        p.src2   = s2;
        p.seq    = fresh_seq();
        return p;
    endfunction

    // Rename in program order against the reference map
    function automatic void predict(fetch_packet_t p);
        issue_packet_t e;
        e         = '0;
        e.valid   = 1'b1;
        e.opcode  = p.opcode;
        e.seq     = p.seq;
        e.src1_pr = ref_map[p.src1];
        e.src2_pr = ref_map[p.src2];
        if (p.opcode != op_store && p.opcode != op_branch) begin
            if (ref_free.size() == 0) begin
                $display("Reference free list is empty when renaming seq %h", p.seq);
                errors++;
            end else begin
                e.dest_pr = ref_free.pop_front();
                displaced.push_back(ref_map[p.dest]);
                ref_map[p.dest] = e.dest_pr;
                alloc_log.push_back(e.dest_pr);
            end
        end
        expected[p.seq]    = e;
        outstanding[p.seq] = 1'b1;
        outstanding_count++;
    endfunction

    function automatic void send(fetch_packet_t p);
        fetch_q.push_back(p);
        predict(p);
    endfunction

    task automatic check_field(string name, int unsigned got, int unsigned want);
        checks++;
        if (got != want) begin
            $display("** Error %s: got %h expected %h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    task automatic check_issue(issue_packet_t got);
        issue_packet_t want;
        want = expected[got.seq];
        checks++;
        if (!outstanding[got.seq]) begin
            $display("Sequence id %h issued unexpectedly or a second time", got.seq);
            errors++;
        end else begin
            check_field($sformatf("issue.opcode seq %h", got.seq), got.opcode, want.opcode);
            check_field($sformatf("issue.dest_pr seq %h", got.seq), got.dest_pr, want.dest_pr);
            check_field($sformatf("issue.src1_pr seq %h", got.seq), got.src1_pr, want.src1_pr);
            check_field($sformatf("issue.src2_pr seq %h", got.seq), got.src2_pr, want.src2_pr);
            outstanding[got.seq] = 1'b0;
            outstanding_count--;
        end
    endtask

    task automatic wait_issued(seq_t s, int limit);
        int n;
        n = 0;
        while (outstanding[s] && n < limit) begin
            @(posedge clock);
            #2;
            n++;
        end
        checks++;
        if (outstanding[s]) begin
            $display("Sequence id %h did not issue within %0d cycles", s, limit);
            errors++;
        end
    endtask

    task automatic wait_drained(int limit);
        int n;
        n = 0;
        while (outstanding_count > 0 && n < limit) begin
            @(posedge clock);
            #2;
            n++;
        end
        checks++;
        if (outstanding_count > 0) begin
            $display("%0d instructions still waiting after %0d cycles", outstanding_count, limit);
            errors++;
        end
    endtask

    task automatic broadcast(pr_t tag);
        @(posedge clock);
        #2;
        cdb.valid = 1'b1;
        cdb.tag   = tag;
        @(posedge clock);
        #2;
        cdb.valid = 1'b0;
    endtask

    // Functional units finish every tag handed out so far
    task automatic complete_all();
        while (alloc_log.size() > 0) begin
            @(posedge clock);
            #2;
            cdb.valid = 1'b1;
            cdb.tag   = alloc_log.pop_front();
        end
        @(posedge clock);
        #2;
        cdb.valid = 1'b0;
    endtask

    // Oldest displaced tags go back, slot 2 first
    task automatic retire_prs();
        pr_t tags [3];
        for (int j = 2; j >= 0; j--) begin
            tags[j] = displaced.pop_front();
            ref_free.push_back(tags[j]);
        end
        @(posedge clock);
        #2;
        for (int j = 0; j < 3; j++) begin
            retire[j].valid = 1'b1;
            retire[j].pr    = tags[j];
        end
        @(posedge clock);
        #2;
        retire = '0;
    endtask

    //////////////////////////////
    // Fetch driver and monitor
    //////////////////////////////
    always @(negedge clock) begin
        take_seen = fetch_take;
    end

    // Untaken instructions come back as the oldest slots
    always @(posedge clock) begin
        int n;
        #2;
        n = (int'(take_seen) < presented) ? int'(take_seen) : presented;
        repeat (n) void'(fetch_q.pop_front());
        presented = (fetch_q.size() < 3) ? fetch_q.size() : 3;
        for (int s = 0; s < 3; s++) begin
            fetch_group[2 - s] = (s < presented) ? fetch_q[s] : '0;
        end
    end

    always @(posedge clock) begin
        #1;
        for (int k = 0; k < 2; k++) begin
            if (issue[k].valid === 1'b1) begin
                check_issue(issue[k]);
            end
        end
    end

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic reset_state();
        check_field("issue[0].valid", issue[0].valid, 0);
        check_field("issue[1].valid", issue[1].valid, 0);
        check_field("fetch_take", fetch_take, 3);
    endtask

    task automatic independent_group();
        fetch_packet_t p [3];
        @(negedge clock);
        p[0] = make_instr(op_alu, 1, 2, 3);
        p[1] = make_instr(op_alu, 4, 5, 6);
        p[2] = make_instr(op_alu, 7, 8, 9);
        for (int k = 0; k < 3; k++) begin
            send(p[k]);
        end
        for (int k = 0; k < 3; k++) begin
            wait_issued(p[k].seq, 20);
        end
        complete_all();
    endtask

    task automatic intra_group_dependency();
        fetch_packet_t older;
        fetch_packet_t younger;
        @(negedge clock);
        older   = make_instr(op_alu, 10, 11, 12);
        younger = make_instr(op_mult, 13, 10, 14);
        send(older);
        send(younger);
        wait_issued(older.seq, 20);
        repeat (4) @(posedge clock);
        #2;
        checks++;
        if (!outstanding[younger.seq]) begin
            $display("Dependent seq %h issued before its source tag completed", younger.seq);
            errors++;
        end
        broadcast(expected[older.seq].dest_pr);
        wait_issued(younger.seq, 20);
        complete_all();
    endtask

    task automatic free_list_exhaustion();
        int            burn;
        fetch_packet_t p [5];
        burn = ref_free.size() - 2;
        // Use up all but two free tags
        @(negedge clock);
        for (int k = 0; k < burn; k++) begin
            send(make_instr(op_alu, ar_t'(16 + k % 8), 30, 31));
        end
        wait_drained(200);
        @(negedge clock);
        p[0] = make_instr(op_alu, 17, 30, 31);
        p[1] = make_instr(op_alu, 18, 30, 31);
        p[2] = make_instr(op_store, 0, 30, 31);
        p[3] = make_instr(op_alu, 19, 30, 31);
        p[4] = make_instr(op_alu, 20, 30, 31);
        for (int k = 0; k < 3; k++) begin
            send(p[k]);
        end
        // Last two wait for tags that only retirement brings
        fetch_q.push_back(p[3]);
        fetch_q.push_back(p[4]);
        for (int k = 0; k < 3; k++) begin
            wait_issued(p[k].seq, 20);
        end
        repeat (3) @(posedge clock);
        #2;
        check_field("fetch_take", fetch_take, 0);
        retire_prs();
        predict(p[3]);
        predict(p[4]);
        wait_drained(40);
        complete_all();
    endtask

    task automatic rs_backpressure();
        fetch_packet_t producer;
        opcode_e       op;
        ar_t           w;
        ar_t           s1;
        ar_t           s2;
        int            waited;
        w  = ar_t'(next_random());
        s1 = ar_t'(next_random());
        s2 = ar_t'(next_random());
        op = opcode_e'(next_random() % 3);
        @(negedge clock);
        producer = make_instr(op, w, s1, s2);
        send(producer);
        // Consumers write no tag and all wait on the producer
        for (int k = 0; k < CONSUMERS; k++) begin
            op = (next_random() % 2) ? op_store : op_branch;
            s2 = ar_t'(next_random());
            send(make_instr(op, 0, w, s2));
        end
        wait_issued(producer.seq, 20);
        waited = 0;
        while (fetch_take != 0 && waited < 40) begin
            @(posedge clock);
            #2;
            waited++;
        end
        repeat (3) @(posedge clock);
        #2;
        check_field("fetch_take", fetch_take, 0);
        check_field("waiting instructions", outstanding_count, CONSUMERS);
        broadcast(expected[producer.seq].dest_pr);
        wait_drained(60);
        // Late duplicates would show up here
        repeat (5) @(posedge clock);
        #2;
        complete_all();
    endtask

    //////////////////////////////
    // Sequence and watchdog
    //////////////////////////////
    initial begin
        reset       = 1'b1;
        fetch_group = '0;
        cdb         = '0;
        retire      = '0;
        for (int a = 0; a < AR_COUNT; a++) begin
            ref_map[a] = pr_t'(a);
        end
        for (int t = AR_COUNT; t < PR_COUNT; t++) begin
            ref_free.push_back(pr_t'(t));
        end
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
        reset_state();
        independent_group();
        intra_group_dependency();
        free_list_exhaustion();
        rs_backpressure();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- hdl/rename_core.sv
/* Rename and dispatch front of a three-wide out-of-order core
   Dispatch buffer, rename, map table, free list and reservation station */
`timescale 1ns/100ps

module rename_core
    import ooo_pkg::*;
#(
    parameter int pr_count = 64,
    parameter int rs_size  = 8
) (
    input  logic                clock,
    input  logic                reset,
    input  fetch_packet_t [2:0] fetch_group,
    output logic [1:0]          fetch_take,
    input  cdb_t                cdb,
    input  retire_t [2:0]       retire,
    output issue_packet_t [1:0] issue
);

    // Buffer and dispatch
    fetch_packet_t [2:0] held;
    logic [2:0]          stall;
    // Rename
    ar_t [2:0]           src1_ar;
    ar_t [2:0]           src2_ar;
    pr_t [2:0]           src1_pr;
    pr_t [2:0]           src2_pr;
    logic [2:0]          src1_ready;
    logic [2:0]          src2_ready;
    pr_t [2:0]           old_pr;
    ar_t [2:0]           dest_ar;
    pr_t [2:0]           dest_pr;
    logic [2:0]          dest_en;
    // Free list
    pr_t [2:0]           free_prs;
    logic [1:0]          free_avail;
    logic [1:0]          alloc_count;
    // Reservation station
    rs_entry_t [2:0]     rs_write;
    logic [3:0]          rs_free;

    //////////////////////////////
    // Front
    //////////////////////////////
    dispatch_buffer buffer0 (
        .clock(clock), .reset(reset), .fetch_group(fetch_group),
        .stall(stall), .held(held), .fetch_take(fetch_take)
    );

    dispatch_stage dispatch0 (
        .held(held), .rs_free(rs_free), .free_prs(free_prs), .free_avail(free_avail),
        .src1_ar(src1_ar), .src2_ar(src2_ar), .src1_pr(src1_pr), .src2_pr(src2_pr),
        .src1_ready(src1_ready), .src2_ready(src2_ready), .old_pr(old_pr),
        .dest_ar(dest_ar), .dest_pr(dest_pr), .dest_en(dest_en),
        .alloc_count(alloc_count), .rs_write(rs_write), .stall(stall)
    );

    //////////////////////////////
    // Rename state
    //////////////////////////////
    map_table #(.pr_count(pr_count)) map0 (
        .clock(clock), .reset(reset), .cdb(cdb),
        .src1_ar(src1_ar), .src2_ar(src2_ar), .dest_ar(dest_ar),
        .src1_pr(src1_pr), .src2_pr(src2_pr),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .old_pr(old_pr), .dest_pr(dest_pr), .dest_en(dest_en)
    );

    free_list #(.pr_count(pr_count)) free0 (
        .clock(clock), .reset(reset), .alloc_count(alloc_count),
        .free_prs(free_prs), .free_avail(free_avail), .retire(retire)
    );

    // Issue side
    reservation_station #(.rs_size(rs_size)) rs0 (
        .clock(clock), .reset(reset), .rs_write(rs_write), .cdb(cdb),
        .rs_free(rs_free), .issue(issue)
    );

endmodule

//--- hdl/reservation_station.sv
/* Reservation station with tag wakeup
   Lowest-index select of two ready entries into a registered issue port */
`timescale 1ns/100ps

module reservation_station
    import ooo_pkg::*;
#(
    parameter int rs_size = 8
) (
    input  logic                clock,
    input  logic                reset,
    input  rs_entry_t [2:0]     rs_write,
    input  cdb_t                cdb,
    output logic [3:0]          rs_free,
    output issue_packet_t [1:0] issue
);

    rs_entry_t [rs_size-1:0] entries;
    rs_entry_t [rs_size-1:0] entries_next;
    issue_packet_t [1:0]     issue_next;

    // Slots free right now, issued entries count from the next cycle
    always_comb begin
        rs_free = '0;
        for (int k = 0; k < rs_size; k++) begin
            if (!entries[k].valid) begin
                rs_free = rs_free + 4'd1;
            end
        end
    end

    always_comb begin
        int   n_pick;
        logic placed;
        n_pick       = 0;
        placed       = 1'b0;
        entries_next = entries;
        issue_next   = '0;

        //////////////////////////////
        // Wakeup
        //////////////////////////////
        for (int k = 0; k < rs_size; k++) begin
            if (cdb.valid && entries[k].src1_pr == cdb.tag) begin
                entries_next[k].src1_ready = 1'b1;
            end
            if (cdb.valid && entries[k].src2_pr == cdb.tag) begin
                entries_next[k].src2_ready = 1'b1;
            end
        end

        //////////////////////////////
        // Select, lowest index first
        //////////////////////////////
        for (int k = 0; k < rs_size; k++) begin
            if (entries_next[k].valid && entries_next[k].src1_ready &&
                entries_next[k].src2_ready && n_pick < 2) begin
                issue_next[n_pick].valid   = 1'b1;
                issue_next[n_pick].opcode  = entries_next[k].opcode;
                issue_next[n_pick].seq     = entries_next[k].seq;
                // No destination, no tag on the issue port
                issue_next[n_pick].dest_pr = entries_next[k].has_dest ?
                                             entries_next[k].dest_pr : '0;
                issue_next[n_pick].src1_pr = entries_next[k].src1_pr;
                issue_next[n_pick].src2_pr = entries_next[k].src2_pr;
                entries_next[k].valid = 1'b0;
                n_pick++;
            end
        end

        //////////////////////////////
        // Allocate
        //////////////////////////////
        // Each new entry takes the lowest slot still empty
        for (int j = 2; j >= 0; j--) begin
            placed = 1'b0;
            if (rs_write[j].valid) begin
                for (int k = 0; k < rs_size; k++) begin
                    if (!placed && !entries_next[k].valid) begin
                        entries_next[k] = rs_write[j];
                        placed = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < rs_size; k++) begin
                entries[k].valid <= 1'b0;
            end
            issue[0].valid <= 1'b0;
            issue[1].valid <= 1'b0;
        end else begin
            entries <= entries_next;
            issue   <= issue_next;
        end
    end

    // Dispatch sizes its group against the reported free count
    a_no_overrun: assert property (
        @(posedge clock) disable iff (reset)
        $countones({rs_write[2].valid, rs_write[1].valid, rs_write[0].valid}) <= rs_free
    ) else $error("more RS writes than the %0d free entries", rs_free);

endmodule

//--- hdl/free_list.sv
/* Free physical register queue
   Up to three allocations from the head and three releases at the tail */
`timescale 1ns/100ps

module free_list
    import ooo_pkg::*;
#(
    parameter int pr_count = 64
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [1:0]       alloc_count,
    output pr_t [2:0]        free_prs,
    output logic [1:0]       free_avail,
    input  retire_t [2:0]    retire
);

    // Pointers wrap at the full tag space
    localparam int QUEUE_DEPTH = 2**PR_WIDTH;
    // Tags not mapped at reset
    localparam int INIT_COUNT  = pr_count - AR_COUNT;

    pr_t               queue [QUEUE_DEPTH];
    logic [PR_WIDTH-1:0] head;
    logic [PR_WIDTH-1:0] tail;
    logic [PR_WIDTH:0]   count;
    logic [1:0]          rel_count;

    // Next three from the head
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            free_prs[k] = queue[head + PR_WIDTH'(k)];
        end
        free_avail = (count >= 3) ? 2'd3 : count[1:0];
        rel_count  = 2'(retire[2].valid) + 2'(retire[1].valid) + 2'(retire[0].valid);
    end

    always_ff @(posedge clock) begin
        logic [PR_WIDTH-1:0] slot;
        if (reset) begin
            for (int k = 0; k < INIT_COUNT; k++) begin
                queue[k] <= pr_t'(AR_COUNT + k);
            end
            head  <= '0;
            tail  <= PR_WIDTH'(INIT_COUNT);
            count <= (PR_WIDTH+1)'(INIT_COUNT);
        end else begin
            // Packed at the tail, retire slot 2 first
            slot = tail;
            for (int j = 2; j >= 0; j--) begin
                if (retire[j].valid) begin
                    queue[slot] <= retire[j].pr;
                    slot = slot + 1'b1;
                end
            end
            head  <= head + alloc_count;
            tail  <= tail + rel_count;
            count <= count - alloc_count + rel_count;
        end
    end

    // Retirement never returns more tags than rename can hold free
    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset)
        int'(count) - int'(alloc_count) + int'(rel_count) <= INIT_COUNT
    ) else $error("free list overflow, count %0d", count);

endmodule

//--- hdl/map_table.sv
/* Architectural to physical register map with ready bits
   Broadcast wakes matching tags, lookups see it in the same cycle */
`timescale 1ns/100ps

module map_table
    import ooo_pkg::*;
#(
    parameter int pr_count = 64
) (
    input  logic       clock,
    input  logic       reset,
    input  cdb_t       cdb,
    input  ar_t [2:0]  src1_ar,
    input  ar_t [2:0]  src2_ar,
    input  ar_t [2:0]  dest_ar,
    output pr_t [2:0]  src1_pr,
    output pr_t [2:0]  src2_pr,
    output logic [2:0] src1_ready,
    output logic [2:0] src2_ready,
    output pr_t [2:0]  old_pr,
    input  pr_t [2:0]  dest_pr,
    input  logic [2:0] dest_en
);

    pr_t                 map [AR_COUNT];
    logic [AR_COUNT-1:0] ready;

    //////////////////////////////
    // Lookups
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            src1_pr[i] = map[src1_ar[i]];
            src2_pr[i] = map[src2_ar[i]];
            // Completion this cycle counts as ready
            src1_ready[i] = ready[src1_ar[i]] ||
                            (cdb.valid && cdb.tag == map[src1_ar[i]]);
            src2_ready[i] = ready[src2_ar[i]] ||
                            (cdb.valid && cdb.tag == map[src2_ar[i]]);
            // Mapping that the new dest replaces
            old_pr[i] = map[dest_ar[i]];
        end
    end

    //////////////////////////////
    // Update
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything committed
            for (int a = 0; a < AR_COUNT; a++) begin
                map[a]   <= pr_t'(a);
                ready[a] <= 1'b1;
            end
        end else begin
            for (int a = 0; a < AR_COUNT; a++) begin
                if (cdb.valid && map[a] == cdb.tag) begin
                    ready[a] <= 1'b1;
                end
            end
            // Slot 0 is youngest and is written last
            for (int j = 2; j >= 0; j--) begin
                if (dest_en[j]) begin
                    map[dest_ar[j]]   <= dest_pr[j];
                    ready[dest_ar[j]] <= 1'b0;
                end
            end
        end
    end

    // Free list only hands out tags inside the physical file
    a_dest_in_range: assert property (
        @(posedge clock) disable iff (reset)
        (!dest_en[2] || dest_pr[2] < pr_count) &&
        (!dest_en[1] || dest_pr[1] < pr_count) &&
        (!dest_en[0] || dest_pr[0] < pr_count)
    ) else $error("dest tag beyond pr_count %0d", pr_count);

endmodule

//--- hdl/dispatch_stage.sv
/* Three-wide in-order rename and allocation
   Picks the dispatch prefix, hands out free tags and builds RS entries */
`timescale 1ns/100ps

module dispatch_stage
    import ooo_pkg::*;
(
    input  fetch_packet_t [2:0] held,
    input  logic [3:0]          rs_free,
    input  pr_t [2:0]           free_prs,
    input  logic [1:0]          free_avail,
    output ar_t [2:0]           src1_ar,
    output ar_t [2:0]           src2_ar,
    input  pr_t [2:0]           src1_pr,
    input  pr_t [2:0]           src2_pr,
    input  logic [2:0]          src1_ready,
    input  logic [2:0]          src2_ready,
    input  pr_t [2:0]           old_pr,
    output ar_t [2:0]           dest_ar,
    output pr_t [2:0]           dest_pr,
    output logic [2:0]          dest_en,
    output logic [1:0]          alloc_count,
    output rs_entry_t [2:0]     rs_write,
    output logic [2:0]          stall
);

    logic [2:0] go;
    logic [2:0] writes;

    //////////////////////////////
    // Dispatch prefix
    //////////////////////////////
    always_comb begin
        int   rs_used;
        int   pr_used;
        logic older_go;
        rs_used  = 0;
        pr_used  = 0;
        older_go = 1'b1;
        // Oldest first, a blocked slot blocks every younger one
        for (int i = 2; i >= 0; i--) begin
            writes[i] = held[i].valid && writes_dest(held[i].opcode);
            go[i] = older_go && (!held[i].valid ||
                    (rs_used < int'(rs_free) &&
                     (!writes[i] || pr_used < int'(free_avail))));
            dest_en[i] = go[i] && writes[i];
            dest_ar[i] = held[i].dest;
            // Free tags go out in queue order
            dest_pr[i] = dest_en[i] ? free_prs[pr_used] : '0;
            if (go[i] && held[i].valid) begin
                rs_used++;
            end
            if (dest_en[i]) begin
                pr_used++;
            end
            older_go = go[i];
        end
        alloc_count = 2'(pr_used);
    end

    assign stall = ~go;

    //////////////////////////////
    // RS entries and bypass
    //////////////////////////////
    always_comb begin
        for (int i = 2; i >= 0; i--) begin
            src1_ar[i] = held[i].src1;
            src2_ar[i] = held[i].src2;
            rs_write[i].valid      = go[i] && held[i].valid;
            rs_write[i].opcode     = held[i].opcode;
            rs_write[i].seq        = held[i].seq;
            rs_write[i].dest_pr    = dest_pr[i];
            rs_write[i].has_dest   = writes[i];
            rs_write[i].src1_pr    = src1_pr[i];
            rs_write[i].src1_ready = src1_ready[i];
            rs_write[i].src2_pr    = src2_pr[i];
            rs_write[i].src2_ready = src2_ready[i];
            // Older producer in the same group, nearest one wins
            for (int j = 2; j > i; j--) begin
                if (dest_en[j] && dest_ar[j] == held[i].src1) begin
                    rs_write[i].src1_pr    = dest_pr[j];
                    rs_write[i].src1_ready = 1'b0;
                end
                if (dest_en[j] && dest_ar[j] == held[i].src2) begin
                    rs_write[i].src2_pr    = dest_pr[j];
                    rs_write[i].src2_ready = 1'b0;
                end
            end
        end
    end

    // A tag from the free list is never the live mapping it replaces
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (dest_en[i]) begin
                assert final (dest_pr[i] != old_pr[i])
                    else $error("slot %0d renamed onto live tag %0d", i, old_pr[i]);
            end
        end
    end

endmodule

//--- hdl/dispatch_buffer.sv
/* Dispatch buffer, three instruction slots between fetch and rename
   Stalled instructions shift to the oldest slots, fetch refills the rest */
`timescale 1ns/100ps

module dispatch_buffer
    import ooo_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  fetch_packet_t [2:0] fetch_group,
    input  logic [2:0]          stall,
    output fetch_packet_t [2:0] held,
    output logic [1:0]          fetch_take
);

    fetch_packet_t [2:0] held_next;

    // Slot 2 is the oldest in both groups
    always_comb begin
        case (stall)
            3'b000: held_next = fetch_group;
            // Youngest held instruction moves up to slot 2
            3'b001: held_next = {held[0], fetch_group[2:1]};
            3'b011: held_next = {held[1:0], fetch_group[2]};
            // Whole group waits
            default: held_next = held;
        endcase
    end

    // Free slots after the edge, so the fetch count
    always_comb begin
        fetch_take = 2'(3 - (stall[2] + stall[1] + stall[0]));
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                held[i].valid <= 1'b0;
            end
        end else begin
            held <= held_next;
        end
    end

    // Dispatch only ever holds back a younger suffix of the group
    a_stall_thermo: assert property (
        @(posedge clock) disable iff (reset)
        stall inside {3'b000, 3'b001, 3'b011, 3'b111}
    ) else $error("dispatch stall %b is not a thermometer", stall);

endmodule

//--- hdl/ooo_pkg.sv
/* Rename and dispatch front shared types
   Register widths, opcodes and the packets that move between stages */
package ooo_pkg;

    //////////////////////////////
    // Register spaces
    //////////////////////////////
    localparam int AR_COUNT  = 32;
    localparam int AR_WIDTH  = 5;
    // Bounds pr_count, 33 up to 64
    localparam int PR_WIDTH  = 6;
    localparam int SEQ_WIDTH = 8;

    typedef logic [AR_WIDTH-1:0]  ar_t;
    typedef logic [PR_WIDTH-1:0]  pr_t;
    typedef logic [SEQ_WIDTH-1:0] seq_t;

    // Four bits keep the fetch packet at 28 bits
    typedef enum logic [3:0] {
        op_alu,
        op_mult,
        op_load,
        op_store,
        op_branch
    } opcode_e;

    // Store and branch leave the register file alone
    function automatic logic writes_dest(opcode_e op);
        return !(op inside {op_store, op_branch});
    endfunction

    //////////////////////////////
    // Packets
    //////////////////////////////
    typedef struct packed {
        logic    valid;
        opcode_e opcode;
        ar_t     dest;
        ar_t     src1;
        ar_t     src2;
        seq_t    seq;
    } fetch_packet_t;

    typedef struct packed {
        logic    valid;
        opcode_e opcode;
        seq_t    seq;
        pr_t     dest_pr;
        logic    has_dest;
        pr_t     src1_pr;
        logic    src1_ready;
        pr_t     src2_pr;
        logic    src2_ready;
    } rs_entry_t;

    typedef struct packed {
        logic    valid;
        opcode_e opcode;
        seq_t    seq;
        pr_t     dest_pr;
        pr_t     src1_pr;
        pr_t     src2_pr;
    } issue_packet_t;

    // One completing tag per cycle
    typedef struct packed {
        logic valid;
        pr_t  tag;
    } cdb_t;

    typedef struct packed {
        logic valid;
        pr_t  pr;
    } retire_t;

endpackage
